/* pipe_trace_top.f */
verilog/trace_pkg.sv
verilog/stage_tag_if.sv
verilog/stage_tag_pipe.sv
verilog/trace_record_store.sv
verilog/retire_fifo.sv
verilog/axil_trace_regs.sv
verilog/pipe_trace_top.sv
tests/pipe_trace_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the pipeline trace testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary -j 0 --top-module pipe_trace_tb -f pipe_trace_top.f -o pipe_trace_sim || exit 1
out=$(./obj_dir/pipe_trace_sim)
echo "$out"
echo "$out" | grep -q "TB PASSED" && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }

/* tests/pipe_trace_tb.sv */
/*
 * Pipeline trace unit testbench
 * CPU stage model drives the stage taps, an AXI4-Lite host drains the
 * retire FIFO and every record is compared with the reference record
 */
`timescale 1ns/10ps
`default_nettype none

module pipe_trace_tb;

    localparam int n_issue     = 90;                  // 20 + 30 + 30 + 10
    localparam int cycle_limit = 40 * n_issue + 200;

    logic        clk = 1'b0;
    logic        rst = 1'b1;
    logic        fetch_valid = 1'b0;
    logic        stall = 1'b0;
    logic        flush = 1'b0;
    logic [31:0] fetch_pc = '0;
    logic [31:0] decode_instr = '0;
    logic [31:0] exe_result = '0;
    logic [31:0] mem_addr = '0;
    logic [31:0] wb_data = '0;
    logic [7:0]  awaddr = '0;
    logic [7:0]  araddr = '0;
    logic [31:0] wdata = '0;
    logic [3:0]  wstrb = '0;
    logic        awvalid = 1'b0;
    logic        wvalid = 1'b0;
    logic        bready = 1'b0;
    logic        arvalid = 1'b0;
    logic        rready = 1'b0;
    logic        awready, wready, bvalid, arready, rvalid;
    logic [1:0]  bresp, rresp;
    logic [31:0] rdata;

    // Stage model with slot 0 as fetch and slot 4 as write-back
    bit v [5];
    int sq [5];                      // Sequence number per stage
    int held [5];                    // Decode cycles spent held so far
    int next_seq = 0;                // Also counts accepted fetches
    int issue_target = 0;
    int stall_left = 0;
    int long_req = 0, long_done = 0;
    int flush_req = 0, flush_done = 0;
    bit stall_mode = 1'b0, flush_mode = 1'b0;
    bit throttle = 1'b1;             // Host is far slower than the pipeline
    int cycles = 0, err_cnt = 0, check_cnt = 0;
    trace_pkg::trace_rec_t exp_q [$];

    pipe_trace_top pipe_trace_top_inst (.*);

    always #4 clk = ~clk;  // 8 ns period

    //////////////////////////////
    // Stage data and reference record
    //////////////////////////////
    function automatic logic [31:0] pc_of(input int s);
        return 32'h1000 + 32'(4 * s);
    endfunction

    function automatic logic [31:0] instr_of(input int s, input int idx);
        return (32'(s) << 8) | 32'(idx);  // Decode-cycle index in the low byte
    endfunction

    function automatic logic [31:0] exe_of(input int s);
        return 32'(s) * 32'h0001_0003 ^ 32'hC0DE_0000;
    endfunction

    function automatic logic [31:0] mem_of(input int s);
        return 32'h2000_0000 + 32'(s) * 32'd16;
    endfunction

    function automatic logic [31:0] wb_of(input int s);
        return ~(32'(s) * 32'h0101_0101);
    endfunction

    function automatic trace_pkg::trace_rec_t expected_rec(input int s, input int n_held);
        trace_pkg::trace_rec_t r;
        r            = '0;
        r.tag        = 8'(s);                             // Tag wraps at 256
        r.stall_cnt  = (n_held > 15) ? 4'd15 : 4'(n_held);  // Saturates
        r.pc         = pc_of(s);
        r.instr      = instr_of(s, n_held);               // Last decode cycle wins
        r.exe_result = exe_of(s);
        r.mem_addr   = mem_of(s);
        r.wb_data    = wb_of(s);
        return r;
    endfunction

    function automatic bit pipe_busy();
        return next_seq < issue_target || v[0] || v[1] || v[2] || v[3] || v[4];
    endfunction

    // Run limit
    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("TB FAILED");
            $finish;
        end
    end

    //////////////////////////////
    // CPU stage model
    //////////////////////////////
    always @(posedge clk) begin : cpu_model
        int outstanding;
        if (!rst) begin
            if (v[4]) exp_q.push_back(expected_rec(sq[4], held[4]));  // Retires this edge
            for (int i = 4; i > 2; i--) begin
                v[i]    = v[i-1];
                sq[i]   = sq[i-1];
                held[i] = held[i-1];
            end
            v[2]    = v[1] && !stall;  // Execute bubble while decode holds
            sq[2]   = sq[1];
            held[2] = held[1];
            if (flush) begin
                v[0] = 1'b0;
                v[1] = 1'b0;
            end else if (!stall) begin
                v[1]    = v[0];
                sq[1]   = sq[0];
                held[1] = 0;
                v[0]    = fetch_valid;
                sq[0]   = next_seq;
            end else if (v[1]) begin
                held[1]++;
            end
            if (fetch_valid && (!stall || flush)) next_seq++;
            #1;
            // Next cycle's controls
            if (long_done != long_req && v[1]) begin
                stall_left = 18;  // Past the counter ceiling
                long_done++;
            end else if (stall_left == 0 && stall_mode && $urandom % 5 == 0) begin
                stall_left = 1 + $urandom % 6;
            end
            stall = stall_left > 0;
            if (stall_left > 0) stall_left--;
            flush = flush_mode && $urandom % 12 == 0;
            if (flush_done != flush_req && stall && v[1]) begin
                flush = 1'b1;     // Flush on top of a held decode
                flush_done++;
            end
            outstanding = exp_q.size();
            for (int i = 0; i < 5; i++) begin
                if (v[i]) outstanding++;
            end
            fetch_valid  = next_seq < issue_target && (!throttle || outstanding < 4);
            fetch_pc     = pc_of(sq[0]);
            decode_instr = instr_of(sq[1], held[1]);
            exe_result   = exe_of(sq[2]);
            mem_addr     = mem_of(sq[3]);
            wb_data      = wb_of(sq[4]);
        end
    end

    //////////////////////////////
    // Host side
    //////////////////////////////
    task automatic check_word(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
        check_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("[ERROR] %0t ns: %s read %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic step_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic read_reg(input logic [7:0] addr, output logic [31:0] data);
        araddr  = addr;
        arvalid = 1'b1;
        while (!arready) step_cycle();
        step_cycle();  // AR handshake on this edge
        arvalid = 1'b0;
        if (!rvalid) begin
            err_cnt++;
            $display("Read of offset %h got no response one cycle after the address", addr);
        end
        repeat ($urandom % 4) step_cycle();  // Host back-pressure
        while (!rvalid) step_cycle();
        rready = 1'b1;
        data   = rdata;
        check_word("rresp", {30'b0, rresp}, 32'd0);
        step_cycle();
        rready = 1'b0;
    endtask

    task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
        awaddr  = addr;
        wdata   = data;
        wstrb   = 4'hF;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        while (!(awready && wready)) step_cycle();
        step_cycle();
        awvalid = 1'b0;
        wvalid  = 1'b0;
        repeat ($urandom % 4) step_cycle();
        while (!bvalid) step_cycle();
        bready = 1'b1;
        check_word("bresp", {30'b0, bresp}, 32'd0);
        step_cycle();
        bready = 1'b0;
    endtask

    // Reads the head record if there is one and pops it
    task automatic drain_record();
        logic [31:0]           w;
        trace_pkg::trace_rec_t e;
        read_reg(trace_pkg::reg_status, w);
        if (!w[0]) return;
        if (exp_q.size() == 0) begin
            err_cnt++;
            $display("The FIFO holds a record that no instruction retired");
            write_reg(trace_pkg::reg_cmd, 32'h1);
            return;
        end
        e = exp_q[0];
        read_reg(trace_pkg::reg_meta, w);
        check_word("meta", w, {20'b0, e.stall_cnt, e.tag});
        read_reg(trace_pkg::reg_pc, w);
        check_word("pc", w, e.pc);
        read_reg(trace_pkg::reg_instr, w);
        check_word("instr", w, e.instr);
        read_reg(trace_pkg::reg_exe, w);
        check_word("exe_result", w, e.exe_result);
        read_reg(trace_pkg::reg_mem, w);
        check_word("mem_addr", w, e.mem_addr);
        read_reg(trace_pkg::reg_wb, w);
        check_word("wb_data", w, e.wb_data);
        write_reg(trace_pkg::reg_cmd, 32'h1);
        exp_q.delete(0);
    endtask

    task automatic drain_all();
        while (pipe_busy() || exp_q.size() > 0) drain_record();
    endtask

    //////////////////////////////
    // Test sequence
    //////////////////////////////
    initial begin : main_seq
        logic [31:0] d;
        int          n;
        void'($urandom(937));
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;
        check_word("handshake outputs after reset",
                   {27'b0, awready, wready, arready, bvalid, rvalid}, 32'h1C);
        for (int a = 4; a <= 24; a += 4) begin
            read_reg(8'(a), d);
            check_word("data register while empty", d, 32'd0);
        end
        read_reg(8'h20, d);
        check_word("unmapped offset", d, 32'd0);
        read_reg(8'hFC, d);
        check_word("unmapped offset", d, 32'd0);
        write_reg(trace_pkg::reg_cmd, 32'h1);  // Pop with nothing queued
        read_reg(trace_pkg::reg_status, d);
        check_word("status after empty pop", d, 32'd0);

        issue_target += 20;  // Plain stream
        drain_all();
        stall_mode = 1'b1;
        issue_target += 30;
        repeat (4) step_cycle();
        long_req++;
        drain_all();
        check_word("long stall bursts", 32'(long_done), 32'd1);
        flush_mode = 1'b1;
        flush_req++;
        issue_target += 30;
        drain_all();
        check_word("flushes while decode held", 32'(flush_done), 32'd1);

        // Overflow with the host idle
        stall_mode   = 1'b0;
        flush_mode   = 1'b0;
        throttle     = 1'b0;
        issue_target += 10;
        while (pipe_busy()) step_cycle();
        n = exp_q.size();
        read_reg(trace_pkg::reg_status, d);
        check_word("status when full", d, {16'b0, 8'(n - 4), 4'b0, 3'd4, 1'b1});
        write_reg(8'h3C, 32'h3);  // Unmapped write aliasing the command offset in its low bits
        read_reg(trace_pkg::reg_status, d);
        check_word("status after unmapped write", d, {16'b0, 8'(n - 4), 4'b0, 3'd4, 1'b1});
        write_reg(trace_pkg::reg_cmd, 32'h2);
        read_reg(trace_pkg::reg_status, d);
        check_word("status after drop clear", d, 32'h9);
        repeat (4) drain_record();  // Oldest four were kept
        exp_q.delete();
        read_reg(trace_pkg::reg_status, d);
        check_word("status after draining", d, 32'd0);

        $display("Checks run: %0d, errors: %0d", check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/axil_trace_regs.sv */
/*
 * AXI4-Lite trace registers
 * Status, the head record's fields and a pop/clear command for the host
 */
`timescale 1ns/10ps
`default_nettype none

module axil_trace_regs (
    input  logic                                clk,
    input  logic                                rst,
    input  logic [trace_pkg::axil_addr_w-1:0]   awaddr,
    input  logic                                awvalid,
    output logic                                awready,
    input  logic [trace_pkg::data_w-1:0]        wdata,
    input  logic [trace_pkg::data_w/8-1:0]      wstrb,
    input  logic                                wvalid,
    output logic                                wready,
    output logic [1:0]                          bresp,
    output logic                                bvalid,
    input  logic                                bready,
    input  logic [trace_pkg::axil_addr_w-1:0]   araddr,
    input  logic                                arvalid,
    output logic                                arready,
    output logic [trace_pkg::data_w-1:0]        rdata,
    output logic [1:0]                          rresp,
    output logic                                rvalid,
    input  logic                                rready,
    input  trace_pkg::trace_rec_t               head_rec,
    input  logic                                not_empty,
    input  logic [2:0]                          level,
    input  logic [7:0]                          drop_cnt,
    output logic                                pop,
    output logic                                drop_clear
);

    logic                         wr_fire, rd_fire, cmd_hit;
    trace_pkg::trace_rec_t        shown;    // Head record, zero when empty
    logic [trace_pkg::data_w-1:0] rd_word;

    //////////////////////////////
    // Write path
    //////////////////////////////
    // AW and W only move as a pair, a lone valid sees ready low
    assign awready = !bvalid && !(awvalid && !wvalid);
    assign wready  = !bvalid && !(wvalid && !awvalid);
    assign wr_fire = awvalid && wvalid && !bvalid;
    assign cmd_hit = wr_fire && awaddr == trace_pkg::reg_cmd && wstrb[0];
    assign bresp   = 2'b00;  // Always OKAY
    assign rresp   = 2'b00;

    always_ff @(posedge clk) begin
        if (rst) begin
            bvalid     <= 1'b0;
            pop        <= 1'b0;
            drop_clear <= 1'b0;
        end else begin
            if (wr_fire) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
            pop        <= cmd_hit && wdata[0];  // One-cycle pulses
            drop_clear <= cmd_hit && wdata[1];
        end
    end

    //////////////////////////////
    // Read path
    //////////////////////////////
    assign arready = !rvalid;  // One read in flight
    assign rd_fire = arvalid && !rvalid;
    assign shown   = not_empty ? head_rec : '0;

    always_comb begin
        case (araddr)
            trace_pkg::reg_status: rd_word = {16'b0, drop_cnt, 4'b0, level, not_empty};
            trace_pkg::reg_meta:   rd_word = {20'b0, shown.stall_cnt, shown.tag};
            trace_pkg::reg_pc:     rd_word = shown.pc;
            trace_pkg::reg_instr:  rd_word = shown.instr;
            trace_pkg::reg_exe:    rd_word = shown.exe_result;
            trace_pkg::reg_mem:    rd_word = shown.mem_addr;
            trace_pkg::reg_wb:     rd_word = shown.wb_data;
            default:               rd_word = '0;  // Unmapped and reg_cmd
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rvalid <= 1'b0;
        end else if (rd_fire) begin
            rvalid <= 1'b1;
        end else if (rready) begin
            rvalid <= 1'b0;
        end
    end

    // Read word held until rready
    always_ff @(posedge clk) begin
        if (rd_fire) rdata <= rd_word;
    end

endmodule

`default_nettype wire

/* verilog/pipe_trace_top.sv */
/*
 * Pipeline trace unit, top level
 * Tag pipeline, record store, retire FIFO and the AXI4-Lite host port
 */
`timescale 1ns/10ps
`default_nettype none

module pipe_trace_top (
    input  logic                               clk,
    input  logic                               rst,
    // CPU stage taps
    input  logic                               fetch_valid,
    input  logic                               stall,
    input  logic                               flush,
    input  logic [trace_pkg::data_w-1:0]       fetch_pc,
    input  logic [trace_pkg::data_w-1:0]       decode_instr,
    input  logic [trace_pkg::data_w-1:0]       exe_result,
    input  logic [trace_pkg::data_w-1:0]       mem_addr,
    input  logic [trace_pkg::data_w-1:0]       wb_data,
    // AXI4-Lite slave
    input  logic [trace_pkg::axil_addr_w-1:0]  awaddr,
    input  logic                               awvalid,
    output logic                               awready,
    input  logic [trace_pkg::data_w-1:0]       wdata,
    input  logic [trace_pkg::data_w/8-1:0]     wstrb,
    input  logic                               wvalid,
    output logic                               wready,
    output logic [1:0]                         bresp,
    output logic                               bvalid,
    input  logic                               bready,
    input  logic [trace_pkg::axil_addr_w-1:0]  araddr,
    input  logic                               arvalid,
    output logic                               arready,
    output logic [trace_pkg::data_w-1:0]       rdata,
    output logic [1:0]                         rresp,
    output logic                               rvalid,
    input  logic                               rready
);

    stage_tag_if tags ();

    logic                  retire_valid;
    trace_pkg::trace_rec_t retire_rec, head_rec;
    logic                  not_empty, pop, drop_clear;
    logic [2:0]            level;
    logic [7:0]            drop_cnt;

    stage_tag_pipe u_tag_pipe (
        .clk(clk), .rst(rst),
        .fetch_valid(fetch_valid), .stall(stall), .flush(flush),
        .tags(tags)
    );

    trace_record_store u_store (
        .clk(clk), .rst(rst), .tags(tags),
        .fetch_pc(fetch_pc), .decode_instr(decode_instr), .exe_result(exe_result),
        .mem_addr(mem_addr), .wb_data(wb_data),
        .retire_valid(retire_valid), .retire_rec(retire_rec)
    );

    retire_fifo u_fifo (
        .clk(clk), .rst(rst),
        .push(retire_valid), .pop(pop), .drop_clear(drop_clear),
        .push_rec(retire_rec), .head_rec(head_rec),
        .not_empty(not_empty), .level(level), .drop_cnt(drop_cnt)
    );

    axil_trace_regs u_regs (
        .clk(clk), .rst(rst),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
        .bresp(bresp), .bvalid(bvalid), .bready(bready),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
        .head_rec(head_rec), .not_empty(not_empty), .level(level),
        .drop_cnt(drop_cnt), .pop(pop), .drop_clear(drop_clear)
    );

endmodule

`default_nettype wire

/* verilog/retire_fifo.sv */
/*
 * Retire FIFO
 * Circular buffer of retire records; a push into a full buffer is dropped
 * and counted in a saturating counter
 */
`timescale 1ns/10ps
`default_nettype none

module retire_fifo (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  push,
    input  logic                  pop,
    input  logic                  drop_clear,
    input  trace_pkg::trace_rec_t push_rec,
    output trace_pkg::trace_rec_t head_rec,
    output logic                  not_empty,
    output logic [2:0]            level,
    output logic [7:0]            drop_cnt
);

    localparam int ptr_w = $clog2(trace_pkg::fifo_depth);

    trace_pkg::trace_rec_t mem [trace_pkg::fifo_depth];
    logic [ptr_w-1:0]      wr_ptr, rd_ptr;  // Wrap on their own, depth is 2^n
    logic                  full, do_push, do_pop;

    assign not_empty = level != 3'd0;
    assign full      = level == 3'(trace_pkg::fifo_depth);
    assign do_pop    = pop && not_empty;
    assign do_push   = push && (!full || do_pop);  // Pop frees the slot this edge
    assign head_rec  = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) mem[wr_ptr] <= push_rec;
    end

    // Pointers and fill level
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            level  <= '0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
            level <= level + 3'(do_push) - 3'(do_pop);
        end
    end

    // Overflow counter, clear wins over a same-cycle drop
    always_ff @(posedge clk) begin
        if (rst || drop_clear) begin
            drop_cnt <= '0;
        end else if (push && !do_push && drop_cnt != 8'hFF) begin
            drop_cnt <= drop_cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

/* verilog/stage_tag_if.sv */
/*
 * Stage tag bundle
 * Valid bits and sequence tags of all five stages, plus the decode hold flag
 */
`timescale 1ns/10ps
`default_nettype none

interface stage_tag_if;

    logic                        f_valid;
    logic                        d_valid;
    logic                        e_valid;
    logic                        m_valid;
    logic                        w_valid;
    logic [trace_pkg::tag_w-1:0] f_tag;
    logic [trace_pkg::tag_w-1:0] d_tag;
    logic [trace_pkg::tag_w-1:0] e_tag;
    logic [trace_pkg::tag_w-1:0] m_tag;
    logic [trace_pkg::tag_w-1:0] w_tag;
    logic                        d_stalled;  // Decode kept last cycle's instruction

    // Tag pipeline side
    modport src (
        output f_valid, d_valid, e_valid, m_valid, w_valid,
        output f_tag, d_tag, e_tag, m_tag, w_tag,
        output d_stalled
    );

    // Record store side
    modport dst (
        input f_valid, d_valid, e_valid, m_valid, w_valid,
        input f_tag, d_tag, e_tag, m_tag, w_tag,
        input d_stalled
    );

endinterface

`default_nettype wire

/* verilog/stage_tag_pipe.sv */
/*
 * Stage tag pipeline
 * Follows each sequence tag from fetch to write-back; stall holds F/D and
 * bubbles execute, flush kills what enters fetch and decode
 */
`timescale 1ns/10ps
`default_nettype none

module stage_tag_pipe (
    input  logic     clk,
    input  logic     rst,
    input  logic     fetch_valid,
    input  logic     stall,
    input  logic     flush,
    stage_tag_if.src tags
);

    logic [trace_pkg::tag_w-1:0] tag_cnt;  // Next tag handed to fetch
    logic                        front_load;  // F and D take new contents

    // Flush overrides the stall hold on the front end
    assign front_load = !stall || flush;

    //////////////////////////////
    // Tag counter
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            tag_cnt <= '0;
        end else if (fetch_valid && front_load) begin
            tag_cnt <= tag_cnt + 1'b1;  // Advances even for a flushed fetch
        end
    end

    //////////////////////////////
    // Stage valids
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            tags.f_valid   <= 1'b0;
            tags.d_valid   <= 1'b0;
            tags.e_valid   <= 1'b0;
            tags.m_valid   <= 1'b0;
            tags.w_valid   <= 1'b0;
            tags.d_stalled <= 1'b0;
        end else begin
            if (flush) begin
                tags.f_valid <= 1'b0;  // Kill incoming fetch
                tags.d_valid <= 1'b0;  // Kill instruction leaving fetch
            end else if (!stall) begin
                tags.f_valid <= fetch_valid;
                tags.d_valid <= tags.f_valid;
            end
            tags.e_valid   <= tags.d_valid && !stall;  // Bubble on stall
            tags.m_valid   <= tags.e_valid;            // Back end drains
            tags.w_valid   <= tags.m_valid;
            tags.d_stalled <= stall && !flush && tags.d_valid;
        end
    end

    // Tags ride along, valids qualify them
    always_ff @(posedge clk) begin
        if (front_load) begin
            tags.f_tag <= tag_cnt;
            tags.d_tag <= tags.f_tag;
        end
        tags.e_tag <= tags.d_tag;
        tags.m_tag <= tags.e_tag;
        tags.w_tag <= tags.m_tag;
    end

endmodule

`default_nettype wire

/* verilog/trace_pkg.sv */
/*
 * Pipeline trace package
 * Holds the retire record layout, the field widths and the AXI4-Lite register map
 */
`default_nettype none

package trace_pkg;

    //////////////////////////////
    // Widths and depths
    //////////////////////////////
    localparam int tag_w       = 8;   // Sequence tag, wraps at 256
    localparam int store_depth = 8;   // Record slots, low tag bits pick one
    localparam int data_w      = 32;  // Every captured field
    localparam int stall_cnt_w = 4;   // Decode stall count, saturating
    localparam int fifo_depth  = 4;   // Retire buffer entries
    localparam int axil_addr_w = 8;

    // Retire record, 192 bits, first field is the MSB
    typedef struct packed {
        logic [tag_w-1:0]                     tag;
        logic [stall_cnt_w-1:0]               stall_cnt;
        logic [data_w-tag_w-stall_cnt_w-1:0]  rsvd;        // Always zero
        logic [data_w-1:0]                    pc;          // Fetch
        logic [data_w-1:0]                    instr;       // Last decode word
        logic [data_w-1:0]                    exe_result;  // Execute
        logic [data_w-1:0]                    mem_addr;    // Memory
        logic [data_w-1:0]                    wb_data;     // Write-back
    } trace_rec_t;

    //////////////////////////////
    // Register map
    //////////////////////////////
    localparam logic [axil_addr_w-1:0] reg_status = 8'h00;  // Level, drops
    localparam logic [axil_addr_w-1:0] reg_meta   = 8'h04;  // Tag and stall count
    localparam logic [axil_addr_w-1:0] reg_pc     = 8'h08;
    localparam logic [axil_addr_w-1:0] reg_instr  = 8'h0C;
    localparam logic [axil_addr_w-1:0] reg_exe    = 8'h10;
    localparam logic [axil_addr_w-1:0] reg_mem    = 8'h14;
    localparam logic [axil_addr_w-1:0] reg_wb     = 8'h18;
    localparam logic [axil_addr_w-1:0] reg_cmd    = 8'h1C;  // Write only

endpackage

`default_nettype wire

/* verilog/trace_record_store.sv */
/*
 * Trace record store
 * Slot array indexed by tag; each stage writes its field, write-back reads
 * the slot out as a complete retire record
 */
`timescale 1ns/10ps
`default_nettype none

module trace_record_store (
    input  logic                          clk,
    input  logic                          rst,
    stage_tag_if.dst                      tags,
    input  logic [trace_pkg::data_w-1:0]  fetch_pc,
    input  logic [trace_pkg::data_w-1:0]  decode_instr,
    input  logic [trace_pkg::data_w-1:0]  exe_result,
    input  logic [trace_pkg::data_w-1:0]  mem_addr,
    input  logic [trace_pkg::data_w-1:0]  wb_data,
    output logic                          retire_valid,
    output trace_pkg::trace_rec_t         retire_rec
);

    localparam int idx_w = $clog2(trace_pkg::store_depth);
    localparam logic [trace_pkg::stall_cnt_w-1:0] cnt_max = '1;

    // One partial record per slot
    logic [trace_pkg::data_w-1:0]      pc_mem    [trace_pkg::store_depth];
    logic [trace_pkg::data_w-1:0]      instr_mem [trace_pkg::store_depth];
    logic [trace_pkg::data_w-1:0]      exe_mem   [trace_pkg::store_depth];
    logic [trace_pkg::data_w-1:0]      addr_mem  [trace_pkg::store_depth];
    logic [trace_pkg::stall_cnt_w-1:0] cnt_mem   [trace_pkg::store_depth];

    logic [idx_w-1:0]                  f_idx, d_idx, e_idx, m_idx, w_idx;
    logic [trace_pkg::stall_cnt_w-1:0] d_cnt_next;

    assign f_idx = tags.f_tag[idx_w-1:0];
    assign d_idx = tags.d_tag[idx_w-1:0];
    assign e_idx = tags.e_tag[idx_w-1:0];
    assign m_idx = tags.m_tag[idx_w-1:0];
    assign w_idx = tags.w_tag[idx_w-1:0];

    // Zero on decode entry, then +1 per held cycle up to the ceiling
    always_comb begin
        if (!tags.d_stalled) begin
            d_cnt_next = '0;
        end else if (cnt_mem[d_idx] == cnt_max) begin
            d_cnt_next = cnt_max;
        end else begin
            d_cnt_next = cnt_mem[d_idx] + 1'b1;
        end
    end

    //////////////////////////////
    // Per-stage capture
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (tags.f_valid) pc_mem[f_idx] <= fetch_pc;            // Last fetch cycle wins
        if (tags.d_valid) instr_mem[d_idx] <= decode_instr;     // Last decode cycle wins
        if (tags.e_valid) exe_mem[e_idx] <= exe_result;
        if (tags.m_valid) addr_mem[m_idx] <= mem_addr;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < trace_pkg::store_depth; i++) begin
                cnt_mem[i] <= '0;
            end
        end else if (tags.d_valid) begin
            cnt_mem[d_idx] <= d_cnt_next;
        end
    end

    // Retire record, write-back data merged in the same cycle
    assign retire_valid = tags.w_valid;

    always_comb begin
        retire_rec            = '0;  // Reserved bits stay zero
        retire_rec.tag        = tags.w_tag;
        retire_rec.stall_cnt  = cnt_mem[w_idx];
        retire_rec.pc         = pc_mem[w_idx];
        retire_rec.instr      = instr_mem[w_idx];
        retire_rec.exe_result = exe_mem[w_idx];
        retire_rec.mem_addr   = addr_mem[w_idx];
        retire_rec.wb_data    = wb_data;
    end

endmodule

`default_nettype wire
